// File: hw/display_config.svh
// ****************************************
// display geometry and scan prescaler macros
// ****************************************
`ifndef DISPLAY_CONFIG_SVH
`define DISPLAY_CONFIG_SVH

// number of digits, one anode each
`define DISPLAY_DIGIT_COUNT 4

// segments per digit, one cathode each
`define DISPLAY_SEGMENT_COUNT 7

// log2 of clock cycles per dot tick
// 2 keeps simulation short, a board build wants something near 14
`define DISPLAY_DOT_DIVIDE_LOG2 2

// a full frame is segments times digits dot ticks
`define DISPLAY_DOTS_PER_FRAME (`DISPLAY_DIGIT_COUNT * `DISPLAY_SEGMENT_COUNT)

`endif

// File: hw/display_types_pkg.sv
// ****************************************
// vector typedefs for digits, segment patterns and scan indices
// ****************************************
`include "display_config.svh"

package display_types_pkg;

	typedef logic [3:0] nybble_t; // one hex digit

	// active low, segment a sits at the top bit and g at bit 0
	typedef logic [`DISPLAY_SEGMENT_COUNT-1:0] segment_pattern_t;

	// one-hot, active high, bit 0 is the rightmost digit
	typedef logic [`DISPLAY_DIGIT_COUNT-1:0] anode_t;

	// segment being strobed, counts 0 to segments minus one
	typedef logic [$clog2(`DISPLAY_SEGMENT_COUNT)-1:0] segment_index_t;

	// digit being shown
	typedef logic [$clog2(`DISPLAY_DIGIT_COUNT)-1:0] digit_index_t;

endpackage

// File: hw/display_bus_pkg.sv
// ****************************************
// value word, glyph frame and buffer state types
// ****************************************

package display_bus_pkg;

	// value handed in by the host, digit 0 in the low nybble
	typedef struct packed {
		display_types_pkg::nybble_t digit3;
		display_types_pkg::nybble_t digit2;
		display_types_pkg::nybble_t digit1;
		display_types_pkg::nybble_t digit0;
	} value_word_s;

	// encoded segment patterns for all four digits
	typedef struct packed {
		display_types_pkg::segment_pattern_t digit3;
		display_types_pkg::segment_pattern_t digit2;
		display_types_pkg::segment_pattern_t digit1;
		display_types_pkg::segment_pattern_t digit0;
	} glyph_frame_s;

	// occupancy of the pending slot in frame_buffer
	typedef enum logic {
		BUFFER_EMPTY = 1'b0,
		BUFFER_PENDING = 1'b1
	} buffer_state_e;

endpackage

// File: hw/scan_timebase.sv
// ****************************************
// prescaler producing the dot tick enable
// ****************************************
`timescale 1ns/1ps
`include "display_config.svh"

module scan_timebase (
	input logic clock,
	input logic reset,
	output logic dot_tick
);

	// free running, wraps every 2^D cycles
	logic [`DISPLAY_DOT_DIVIDE_LOG2-1:0] dot_count;

	always_ff @(posedge clock) begin
		if (reset) begin
			dot_count <= '0;
		end else begin
			dot_count <= dot_count + 1'b1;
		end
	end

	// one cycle pulse when the counter is at its top value
	// the first one lands on cycle 2^D-1 after reset release
	assign dot_tick = &dot_count;

	// the counter sits at zero through reset so no tick fires early
	// and the scanner starts cleanly on the first full period

endmodule

// File: hw/glyph_encoder.sv
// ****************************************
// hex value to seven segment glyph encoder
// registered output slot with valid/ready on both sides
// ****************************************
`timescale 1ns/1ps

module glyph_encoder (
	input logic clock,
	input logic reset,
	input logic value_valid,
	input display_bus_pkg::value_word_s value,
	output logic value_ready,
	output logic frame_valid,
	output display_bus_pkg::glyph_frame_s frame,
	input logic frame_ready
);

	// active low pattern, bit 6 is segment a and bit 0 is segment g
	function automatic display_types_pkg::segment_pattern_t encode_nybble(
		input display_types_pkg::nybble_t digit
	);
		display_types_pkg::segment_pattern_t pattern;
		case (digit)
			4'h0: pattern = 7'b0000001;
			4'h1: pattern = 7'b1001111;
			4'h2: pattern = 7'b0010010;
			4'h3: pattern = 7'b0000110;
			4'h4: pattern = 7'b1001100;
			4'h5: pattern = 7'b0100100;
			4'h6: pattern = 7'b0100000;
			4'h7: pattern = 7'b0001111;
			4'h8: pattern = 7'b0000000; // all segments lit
			4'h9: pattern = 7'b0000100;
			4'ha: pattern = 7'b0001000;
			4'hb: pattern = 7'b1100000; // lower case b
			4'hc: pattern = 7'b1110010; // lower case c
			4'hd: pattern = 7'b1000010; // lower case d
			4'he: pattern = 7'b0110000;
			default: pattern = 7'b0111000; // f
		endcase
		return pattern;
	endfunction

	logic take_value;

	// the slot can refill in the same cycle the buffer drains it
	assign value_ready = !frame_valid || frame_ready;
	assign take_value = value_valid && value_ready;

	always_ff @(posedge clock) begin
		if (reset) begin
			frame_valid <= 1'b0;
		end else if (take_value) begin
			frame_valid <= 1'b1;
		end else if (frame_ready) begin
			frame_valid <= 1'b0; // drained with nothing new behind it
		end
	end

	always_ff @(posedge clock) begin
		if (take_value) begin
			frame.digit0 <= encode_nybble(value.digit0);
			frame.digit1 <= encode_nybble(value.digit1);
			frame.digit2 <= encode_nybble(value.digit2);
			frame.digit3 <= encode_nybble(value.digit3);
		end
	end

	// a stalled frame must not change before the buffer takes it
	assert property (@(posedge clock) disable iff (reset)
		frame_valid && !frame_ready |=> frame_valid && $stable(frame))
		else $error("encoder frame changed while stalled");

endmodule

// File: hw/frame_buffer.sv
// ****************************************
// pending and active frame registers
// pending is promoted to active only at a frame boundary
// ****************************************
`timescale 1ns/1ps

module frame_buffer (
	input logic clock,
	input logic reset,
	input logic frame_valid,
	input display_bus_pkg::glyph_frame_s frame,
	output logic frame_ready,
	input logic frame_boundary,
	output display_bus_pkg::glyph_frame_s active_frame
);

	display_bus_pkg::buffer_state_e state;
	display_bus_pkg::glyph_frame_s pending_frame;

	assign frame_ready = (state == display_bus_pkg::BUFFER_EMPTY);

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= display_bus_pkg::BUFFER_EMPTY;
			active_frame <= '1; // every segment dark
		end else begin
			case (state)
				display_bus_pkg::BUFFER_EMPTY: begin
					if (frame_valid) begin
						state <= display_bus_pkg::BUFFER_PENDING;
					end
				end
				default: begin
					if (frame_boundary) begin
						active_frame <= pending_frame; // first seen on digit 0, segment a
						state <= display_bus_pkg::BUFFER_EMPTY;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (frame_valid && frame_ready) begin
			pending_frame <= frame;
		end
	end

	// a held frame must wait for the boundary, never be overwritten
	assert property (@(posedge clock) disable iff (reset)
		state == display_bus_pkg::BUFFER_PENDING |=> $stable(pending_frame))
		else $error("frame accepted while pending slot is full");

endmodule

// File: hw/digit_scanner.sv
// ****************************************
// digit scanner, one anode and at most one segment strobe at a time
// ****************************************
`timescale 1ns/1ps
`include "display_config.svh"

module digit_scanner (
	input logic clock,
	input logic reset,
	input logic dot_tick,
	input display_bus_pkg::glyph_frame_s active_frame,
	output logic frame_boundary,
	output display_types_pkg::anode_t anode,
	output display_types_pkg::segment_pattern_t cathode
);

	// indices point at the segment loaded into the outputs on the next tick
	display_types_pkg::segment_index_t segment_index;
	display_types_pkg::digit_index_t digit_index;
	display_types_pkg::segment_pattern_t digit_pattern;
	display_types_pkg::segment_pattern_t cathode_next;
	logic last_segment;
	logic last_digit;

	assign last_segment = (segment_index ==
		display_types_pkg::segment_index_t'(`DISPLAY_SEGMENT_COUNT - 1));
	assign last_digit = (digit_index ==
		display_types_pkg::digit_index_t'(`DISPLAY_DIGIT_COUNT - 1));

	// the tick that loads the final segment of digit 3 wraps the scan
	assign frame_boundary = dot_tick && last_segment && last_digit;

	always_comb begin
		case (digit_index)
			2'd0: digit_pattern = active_frame.digit0;
			2'd1: digit_pattern = active_frame.digit1;
			2'd2: digit_pattern = active_frame.digit2;
			default: digit_pattern = active_frame.digit3;
		endcase
	end

	// light this segment if the glyph wants it, release all the others
	always_comb begin
		cathode_next = '1;
		cathode_next[segment_index] = digit_pattern[`DISPLAY_SEGMENT_COUNT - 1 - segment_index];
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			segment_index <= '0;
			digit_index <= '0;
			anode <= display_types_pkg::anode_t'(1); // digit 0
			cathode <= '1;
		end else if (dot_tick) begin
			anode <= display_types_pkg::anode_t'(1) << digit_index;
			cathode <= cathode_next;
			if (last_segment) begin
				segment_index <= '0;
				digit_index <= last_digit ? '0 : digit_index + 1'b1;
			end else begin
				segment_index <= segment_index + 1'b1;
			end
		end
	end

	// exactly one digit driven at any time
	assert property (@(posedge clock) disable iff (reset) $onehot(anode))
		else $error("anode is not one-hot");

	// never two segments sinking current together
	assert property (@(posedge clock) disable iff (reset) $countones(~cathode) <= 1)
		else $error("more than one cathode strobe low");

endmodule

// File: hw/segment_display_top.sv
// ****************************************
// four digit seven segment display driver top level
// ****************************************
`timescale 1ns/1ps

module segment_display_top (
	input logic clock,
	input logic reset,
	input logic value_valid,
	input display_bus_pkg::value_word_s value,
	output logic value_ready,
	output display_types_pkg::anode_t anode,
	output display_types_pkg::segment_pattern_t cathode
);

	logic dot_tick;
	logic frame_valid;
	logic frame_ready;
	logic frame_boundary;
	display_bus_pkg::glyph_frame_s frame; // encoder to buffer
	display_bus_pkg::glyph_frame_s active_frame; // buffer to scanner

	scan_timebase u_timebase (
		.clock(clock),
		.reset(reset),
		.dot_tick(dot_tick)
	);

	glyph_encoder u_encoder (
		.clock(clock),
		.reset(reset),
		.value_valid(value_valid),
		.value(value),
		.value_ready(value_ready),
		.frame_valid(frame_valid),
		.frame(frame),
		.frame_ready(frame_ready)
	);

	frame_buffer u_buffer (
		.clock(clock),
		.reset(reset),
		.frame_valid(frame_valid),
		.frame(frame),
		.frame_ready(frame_ready),
		.frame_boundary(frame_boundary),
		.active_frame(active_frame)
	);

	digit_scanner u_scanner (
		.clock(clock),
		.reset(reset),
		.dot_tick(dot_tick),
		.active_frame(active_frame),
		.frame_boundary(frame_boundary),
		.anode(anode),
		.cathode(cathode)
	);

endmodule

// File: verification/segment_display_tb.sv
// ****************************************
// testbench for the seven segment display driver
// cycle reference model, per cycle comparison, directed and random values
// ****************************************
`timescale 1ns/1ps
`include "display_config.svh"

module segment_display_tb;

	localparam int DIVIDE = 1 << `DISPLAY_DOT_DIVIDE_LOG2;
	localparam int SEGMENTS = `DISPLAY_SEGMENT_COUNT;
	localparam int DOTS = `DISPLAY_DOTS_PER_FRAME;
	localparam int FRAME_CYCLES = DOTS * DIVIDE;
	// directed part needs about 14 frames, each random value at most 2.5
	localparam int TIMEOUT_CYCLES = 60 * FRAME_CYCLES + 100;

	logic clock;
	logic reset;
	logic value_valid;
	display_bus_pkg::value_word_s value;
	logic value_ready;
	display_types_pkg::anode_t anode;
	display_types_pkg::segment_pattern_t cathode;

	logic model_live; // model has been through reset
	logic enc_full;
	logic pending_full;
	logic shown_blank;
	logic boundary_seen; // the previous edge wrapped the frame
	logic [15:0] enc_value;
	logic [15:0] pending_value;
	logic [15:0] shown_value;
	logic [3:0] exp_anode;
	logic [6:0] exp_cathode;
	int cycle_count;
	int dot_number;
	int timeout_count;
	logic [31:0] lcg_state;
	logic [15:0] sent_values [$];
	logic [15:0] shown_values [$];

	segment_display_top u_dut (
		.clock(clock),
		.reset(reset),
		.value_valid(value_valid),
		.value(value),
		.value_ready(value_ready),
		.anode(anode),
		.cathode(cathode)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	// hex glyph table, active low, segment a in bit 6
	function automatic logic [6:0] glyph_of(input logic [3:0] digit);
		case (digit)
			4'h0: return 7'b0000001;
			4'h1: return 7'b1001111;
			4'h2: return 7'b0010010;
			4'h3: return 7'b0000110;
			4'h4: return 7'b1001100;
			4'h5: return 7'b0100100;
			4'h6: return 7'b0100000;
			4'h7: return 7'b0001111;
			4'h8: return 7'b0000000;
			4'h9: return 7'b0000100;
			4'ha: return 7'b0001000;
			4'hb: return 7'b1100000;
			4'hc: return 7'b1110010;
			4'hd: return 7'b1000010;
			4'he: return 7'b0110000;
			default: return 7'b0111000;
		endcase
	endfunction

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("ERROR at %0t: %s is %0h, expected %0h", $time, name, actual, expected);
			$display("Done: errors found");
			$fatal(1, "stopping at the first mismatch");
		end
	endtask

	// hold valid until the DUT takes the word, count the stalled edges
	task automatic send_value(input logic [15:0] word, output int stall_cycles);
		stall_cycles = 0;
		@(posedge clock);
		value_valid <= 1'b1;
		value <= word;
		@(posedge clock);
		while (!value_ready) begin
			stall_cycles++;
			@(posedge clock);
		end
		value_valid <= 1'b0;
		sent_values.push_back(word);
	endtask

	task automatic wait_boundary();
		@(posedge clock);
		while (!boundary_seen) @(posedge clock);
	endtask

	task automatic wait_cycles(input int count);
		repeat (count) @(posedge clock);
	endtask

	// expected behavior built from the timing rules, one step per edge
	always @(posedge clock) begin : reference_model
		logic tick;
		logic wrap;
		logic take;
		logic [2:0] seg;
		logic [1:0] dig;
		logic [6:0] pattern;
		logic [6:0] cath;
		if (reset) begin
			model_live <= 1'b1;
			cycle_count <= 0;
			dot_number <= 0;
			enc_full <= 1'b0;
			pending_full <= 1'b0;
			shown_blank <= 1'b1;
			boundary_seen <= 1'b0;
			exp_anode <= 4'b0001;
			exp_cathode <= '1;
		end else begin
			tick = (cycle_count % DIVIDE) == DIVIDE - 1;
			wrap = tick && (dot_number % DOTS == DOTS - 1);
			seg = 3'(dot_number % SEGMENTS);
			dig = 2'(dot_number / SEGMENTS);
			take = value_valid && (!enc_full || !pending_full);
			boundary_seen <= wrap;
			if (tick) begin
				pattern = shown_blank ? 7'h7f : glyph_of(4'(shown_value >> {dig, 2'b00}));
				cath = '1;
				cath[seg] = pattern[3'd6 - seg]; // one strobe per dot tick
				exp_anode <= 4'b0001 << dig;
				exp_cathode <= cath;
				dot_number <= dot_number + 1;
			end
			if (pending_full && wrap) begin
				shown_blank <= 1'b0;
				shown_value <= pending_value;
				pending_full <= 1'b0;
				shown_values.push_back(pending_value);
			end else if (!pending_full && enc_full) begin
				pending_full <= 1'b1;
				pending_value <= enc_value;
			end
			if (take) begin
				enc_full <= 1'b1;
				enc_value <= value;
			end else if (enc_full && !pending_full) begin
				enc_full <= 1'b0;
			end
			cycle_count <= cycle_count + 1;
		end
	end

	// outputs settle after the rising edge, so compare on the falling one
	always @(negedge clock) begin
		if (model_live) begin
			check_value("anode", 32'(anode), 32'(exp_anode));
			check_value("cathode", 32'(cathode), 32'(exp_cathode));
			check_value("value_ready", 32'(value_ready), 32'(!enc_full || !pending_full));
		end
	end

	always @(posedge clock) begin
		timeout_count <= timeout_count + 1;
		if (timeout_count >= TIMEOUT_CYCLES) begin
			$display("simulation did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Done: errors found");
			$fatal(1, "timeout");
		end
	end

	initial begin
		int stall;
		logic [15:0] word;
		reset = 1'b1;
		value_valid = 1'b0;
		value = '0;
		model_live = 1'b0;
		timeout_count = 0;
		lcg_state = 32'hd3d4a938;
		repeat (10) @(posedge clock);
		reset <= 1'b0;
		wait_boundary(); // one blank scan before any value
		send_value(16'h3210, stall);
		wait_boundary();
		send_value(16'h7654, stall);
		wait_boundary();
		send_value(16'hba98, stall);
		wait_boundary();
		send_value(16'hfedc, stall);
		wait_boundary();
		// halfway into a frame, the model shows it only after the next wrap
		wait_cycles(FRAME_CYCLES / 2);
		send_value(16'h0f1e, stall);
		wait_boundary();
		wait_boundary();
		send_value(16'h1234, stall);
		send_value(16'h5678, stall); // waits in the encoder
		send_value(16'h9abc, stall);
		check_value("value_ready stall", 32'(stall > 0), 32'd1);
		repeat (12) begin
			lcg_state = lcg_next(lcg_state);
			word = lcg_state[31:16];
			lcg_state = lcg_next(lcg_state);
			wait_cycles(int'(lcg_state >> 25));
			send_value(word, stall);
		end
		while (enc_full || pending_full) @(posedge clock);
		wait_boundary(); // last value stays up for a whole frame
		check_value("frames shown", shown_values.size(), sent_values.size());
		foreach (sent_values[i]) begin
			check_value("shown value", 32'(shown_values[i]), 32'(sent_values[i]));
		end
		$display("Done: no errors");
		$finish;
	end

endmodule

// File: sim.f
+incdir+hw
hw/display_types_pkg.sv
hw/display_bus_pkg.sv
hw/scan_timebase.sv
hw/glyph_encoder.sv
hw/frame_buffer.sv
hw/digit_scanner.sv
hw/segment_display_top.sv
verification/segment_display_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f sim.f --top-module segment_display_tb -o segment_display_sim

sim_output=$(./obj_dir/segment_display_sim 2>&1 || true)
echo "$sim_output"

if echo "$sim_output" | grep -qx "Done: no errors"; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed"
	exit 1
fi
